//--- list.f
+incdir+design
design/ctrlPkg.sv
design/instrDecoder.sv
design/stepSequencer.sv
design/controlWord.sv
design/controlUnit.sv
tests/controlChecker.sv
tests/controlUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= controlUnitTb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
PASS_TEXT := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/controlUnitTb.sv
`default_nettype none
`timescale 1ns/10ps

`include "ctrl_cfg.svh"

module controlUnitTb import ctrlPkg::*; ();

    localparam int numTests = 14;
    localparam int periodNs = 100;

    logic clk;
    logic reset;
    instrWord_t instr;
    logic [63:0] testName;
    logic [31:0] expCycles;
    logic [1:0] expSize;
    wire [31:0] errorCount;

    wire memWrite;
    wire irWrite;
    wire regWrite;
    wire pcWrite;
    wire regAWrite;
    wire regBWrite;
    wire aluOutWrite;
    wire resetOut;
    wire [2:0] aluOp;
    wire [1:0] pcSource;
    wire [2:0] iorD;
    wire [1:0] regDst;
    wire [2:0] dataSrc;
    wire [1:0] aluSrcA;
    wire [1:0] aluSrcB;
    wire [1:0] storeSize;
    wire [1:0] loadSize;

    // Name, opcode, funct, execute cycles, expected load or store size
    logic [63:0] names [numTests];
    logic [5:0] opcodes [numTests];
    logic [5:0] functs [numTests];
    int cycleCounts [numTests];
    logic [1:0] sizeCodes [numTests];

    int cycle = 0;
    int cycleLimit;
    int nextIdx = 0;
    logic [31:0] rngState = 32'hc88b;

    controlUnit controlUnit_inst (.*);

    controlChecker checker_inst (.*);

    always #(periodNs / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic addEntry(input int idx, input logic [63:0] name, input logic [5:0] op,
                            input logic [5:0] fn, input int cycles, input logic [1:0] sz);
        names[idx] = name;
        opcodes[idx] = op;
        functs[idx] = fn;
        cycleCounts[idx] = cycles;
        sizeCodes[idx] = sz;
    endtask

    // Register fields the control unit ignores get random bits
    task automatic driveEntry(input int idx);
        instrWord_t w;
        rngState = xorshift(rngState);
        w = rngState;
        w.iView.opcode = opcodes[idx];
        if (opcodes[idx] == `CTRL_OP_RTYPE) begin
            w.rView.funct = functs[idx];
        end
        instr <= w;
        testName <= names[idx];
        expCycles <= cycleCounts[idx];
        expSize <= sizeCodes[idx];
    endtask

    task automatic endRun(input bit hung);
        if (hung) begin
            $display("Timeout: the run hung with %0d of %0d instructions issued",
                     nextIdx, numTests);
        end
        $display("Summary: %0d check errors, %0d timeouts", errorCount, int'(hung));
        if (errorCount == 0 && !hung) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instr = '0;
        testName = '0;
        expCycles = '0;
        expSize = '0;
        addEntry(0, "LW", `CTRL_OP_LW, 6'b000000, 5, 2'b01);
        addEntry(1, "LH", `CTRL_OP_LH, 6'b000000, 5, 2'b11);
        addEntry(2, "LB", `CTRL_OP_LB, 6'b000000, 5, 2'b10);
        addEntry(3, "SW", `CTRL_OP_SW, 6'b000000, 5, 2'b01);
        addEntry(4, "SH", `CTRL_OP_SH, 6'b000000, 5, 2'b11);
        addEntry(5, "SB", `CTRL_OP_SB, 6'b000000, 5, 2'b10);
        addEntry(6, "LUI", `CTRL_OP_LUI, 6'b000000, 1, 2'b00);
        addEntry(7, "BREAK", `CTRL_OP_RTYPE, `CTRL_FUNCT_BREAK, 2, 2'b00);
        addEntry(8, "RTE", `CTRL_OP_RTYPE, `CTRL_FUNCT_RTE, 2, 2'b00);
        addEntry(9, "SOFTRST", `CTRL_OP_RESET, 6'b000000, 1, 2'b00);
        addEntry(10, "LW_AGAIN", `CTRL_OP_LW, 6'b000000, 5, 2'b01);
        // Unsupported funct and opcode go straight back to fetch
        addEntry(11, "ADD", `CTRL_OP_RTYPE, 6'b100000, 0, 2'b00);
        addEntry(12, "BEQ", 6'b000100, 6'b000000, 0, 2'b00);
        addEntry(13, "SB_LAST", `CTRL_OP_SB, 6'b000000, 5, 2'b10);
        cycleLimit = 20;
        for (int i = 0; i < numTests; i++) begin
            cycleLimit += `CTRL_FETCH_STEPS + cycleCounts[i];
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= cycleLimit) begin
            endRun(1'b1);
        end else if (!reset && irWrite) begin
            if (nextIdx < numTests) begin
                driveEntry(nextIdx);
                nextIdx = nextIdx + 1;
            end else begin
                // Window of the last entry closed on the falling edge before
                endRun(1'b0);
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/controlChecker.sv
`default_nettype none
`timescale 1ns/10ps

`include "ctrl_cfg.svh"

module controlChecker import ctrlPkg::*; (
    input wire clk,
    input wire reset,
    input wire instrWord_t instr,
    input wire [63:0] testName,
    input wire [31:0] expCycles,
    input wire [1:0] expSize,
    input wire irWrite,
    input wire memWrite,
    input wire regWrite,
    input wire pcWrite,
    input wire regAWrite,
    input wire regBWrite,
    input wire aluOutWrite,
    input wire resetOut,
    input wire [2:0] aluOp,
    input wire [1:0] pcSource,
    input wire [2:0] iorD,
    input wire [1:0] regDst,
    input wire [2:0] dataSrc,
    input wire [1:0] storeSize,
    input wire [1:0] loadSize,
    output wire [31:0] errorCount
);

    localparam int fetchCycles = 6;
    // Counted from the first clock edge that sees reset low
    localparam int releaseDelay = 4;
    // Window cycle of the address step, after fetch steps 4 and 5
    localparam int addrOffset = 3;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic loadOp;
    logic storeOp;
    logic luiOp;
    logic breakOp;
    logic rteOp;
    logic softOp;

    int errors = 0;
    int edgesLow = 0;
    int lastIrEdge = 0;
    int pulses = 0;
    int memCount = 0;
    int regCount = 0;
    int pcCount = 0;
    int rstCount = 0;
    int aCount = 0;
    int bCount = 0;
    int aluOutCount = 0;
    int iorCount = 0;

    assign errorCount = errors;
    assign opcode = instr.iView.opcode;
    assign funct = instr.rView.funct;
    assign loadOp = opcode == `CTRL_OP_LW || opcode == `CTRL_OP_LH || opcode == `CTRL_OP_LB;
    assign storeOp = opcode == `CTRL_OP_SW || opcode == `CTRL_OP_SH || opcode == `CTRL_OP_SB;
    assign luiOp = opcode == `CTRL_OP_LUI;
    assign breakOp = opcode == `CTRL_OP_RTYPE && funct == `CTRL_FUNCT_BREAK;
    assign rteOp = opcode == `CTRL_OP_RTYPE && funct == `CTRL_FUNCT_RTE;
    assign softOp = opcode == `CTRL_OP_RESET;

    task automatic expectValue(input logic [63:0] name, input string what,
                               input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("Fail %s: %s expected %0d actual %0d", name, what, expected, actual);
        end
    endtask

    // One cycle of an execute window
    task automatic sampleExecute(input int offset);
        if (memWrite) begin
            memCount++;
            expectValue(testName, "storeSize", int'(expSize), int'(storeSize));
        end
        if (regWrite) begin
            regCount++;
            expectValue(testName, "regDst", int'(luiOp ? 2'b01 : 2'b11), int'(regDst));
            expectValue(testName, "dataSrc", int'(luiOp ? 3'b101 : 3'b111), int'(dataSrc));
            if (loadOp) begin
                expectValue(testName, "loadSize", int'(expSize), int'(loadSize));
            end
        end
        if (pcWrite) begin
            pcCount++;
            expectValue(testName, "pcSource", int'(rteOp ? 2'b11 : 2'b01), int'(pcSource));
            if (breakOp) begin
                expectValue(testName, "aluOp", int'(3'b010), int'(aluOp));
            end
        end
        if (resetOut) begin
            rstCount++;
        end
        if (regAWrite) begin
            aCount++;
        end
        if (regBWrite) begin
            bCount++;
        end
        if (aluOutWrite) begin
            aluOutCount++;
        end
        // Memory ops must select the address on each wait cycle
        if (iorD != 3'b000) begin
            if (!(loadOp || storeOp)
                || (offset > addrOffset && offset <= addrOffset + `CTRL_MEM_WAIT)) begin
                iorCount++;
            end
        end
    endtask

    task automatic closeWindow(input int gap);
        expectValue(testName, "irWrite spacing", fetchCycles + int'(expCycles), gap);
        expectValue(testName, "memWrite pulses", int'(storeOp), memCount);
        expectValue(testName, "regWrite pulses", int'(loadOp || luiOp), regCount);
        expectValue(testName, "pcWrite pulses", int'(breakOp || rteOp), pcCount);
        expectValue(testName, "resetOut pulses", int'(softOp), rstCount);
        expectValue(testName, "regAWrite pulses", 1, aCount);
        expectValue(testName, "regBWrite pulses", 1, bCount);
        expectValue(testName, "aluOutWrite pulses", 1 + int'(loadOp || storeOp), aluOutCount);
        expectValue(testName, "iorD wait cycles", (loadOp || storeOp) ? `CTRL_MEM_WAIT : 0,
                    iorCount);
    endtask

    always @(posedge clk) begin
        edgesLow = reset ? 0 : edgesLow + 1;
    end

    // Outputs are registered on the rising edge, so sample on the falling one
    always @(negedge clk) begin
        if (reset || edgesLow == 0) begin
            expectValue("RESET", "resetOut", 1, int'(resetOut));
            expectValue("RESET", "regWrite", 1, int'(regWrite));
        end else if (irWrite) begin
            if (pulses == 0) begin
                expectValue("RESET", "cycles to first irWrite", releaseDelay, edgesLow - 1);
            end else begin
                closeWindow(edgesLow - lastIrEdge);
            end
            lastIrEdge = edgesLow;
            pulses++;
            memCount = 0;
            regCount = 0;
            pcCount = 0;
            rstCount = 0;
            aCount = 0;
            bCount = 0;
            aluOutCount = 0;
            iorCount = 0;
        end else if (pulses > 0) begin
            sampleExecute(edgesLow - lastIrEdge);
        end
    end

endmodule

`default_nettype wire

//--- design/controlUnit.sv
`default_nettype none
`timescale 1ns/10ps

`include "ctrl_cfg.svh"

module controlUnit import ctrlPkg::*; (
    input wire clk,
    input wire reset,
    input wire instrWord_t instr,
    output logic memWrite,
    output logic irWrite,
    output logic regWrite,
    output logic pcWrite,
    output logic regAWrite,
    output logic regBWrite,
    output logic aluOutWrite,
    output logic resetOut,
    output logic [2:0] aluOp,
    output logic [1:0] pcSource,
    output logic [2:0] iorD,
    output logic [1:0] regDst,
    output logic [2:0] dataSrc,
    output logic [1:0] aluSrcA,
    output logic [1:0] aluSrcB,
    output logic [1:0] storeSize,
    output logic [1:0] loadSize
);

    opClass_t opClass;
    memSize_t memSize;
    phase_t phase;
    logic [`CTRL_STEP_W-1:0] step;
    memSize_t size;

    instrDecoder decoder_inst (
        .instr(instr),
        .opClass(opClass),
        .memSize(memSize)
    );

    stepSequencer sequencer_inst (
        .clk(clk),
        .reset(reset),
        .opClass(opClass),
        .memSize(memSize),
        .phase(phase),
        .step(step),
        .size(size)
    );

    controlWord word_inst (
        .clk(clk),
        .reset(reset),
        .phase(phase),
        .step(step),
        .size(size),
        .memWrite(memWrite),
        .irWrite(irWrite),
        .regWrite(regWrite),
        .pcWrite(pcWrite),
        .regAWrite(regAWrite),
        .regBWrite(regBWrite),
        .aluOutWrite(aluOutWrite),
        .resetOut(resetOut),
        .aluOp(aluOp),
        .pcSource(pcSource),
        .iorD(iorD),
        .regDst(regDst),
        .dataSrc(dataSrc),
        .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB),
        .storeSize(storeSize),
        .loadSize(loadSize)
    );

endmodule

`default_nettype wire

//--- design/controlWord.sv
`default_nettype none
`timescale 1ns/10ps

`include "ctrl_cfg.svh"

module controlWord import ctrlPkg::*; (
    input wire clk,
    input wire reset,
    input wire phase_t phase,
    input wire [`CTRL_STEP_W-1:0] step,
    input wire memSize_t size,
    output logic memWrite,
    output logic irWrite,
    output logic regWrite,
    output logic pcWrite,
    output logic regAWrite,
    output logic regBWrite,
    output logic aluOutWrite,
    output logic resetOut,
    output logic [2:0] aluOp,
    output logic [1:0] pcSource,
    output logic [2:0] iorD,
    output logic [1:0] regDst,
    output logic [2:0] dataSrc,
    output logic [1:0] aluSrcA,
    output logic [1:0] aluSrcB,
    output logic [1:0] storeSize,
    output logic [1:0] loadSize
);

    localparam logic [`CTRL_STEP_W-1:0] irStep = `CTRL_STEP_W'(3);
    localparam logic [`CTRL_STEP_W-1:0] decodeStep = `CTRL_STEP_W'(4);
    localparam logic [`CTRL_STEP_W-1:0] fetchLast = `CTRL_STEP_W'(`CTRL_FETCH_STEPS - 1);
    localparam logic [`CTRL_STEP_W-1:0] memLast = `CTRL_STEP_W'(`CTRL_MEM_WAIT + 1);

    always_ff @(posedge clk) begin
        memWrite <= 1'b0;
        irWrite <= 1'b0;
        regWrite <= 1'b0;
        pcWrite <= 1'b0;
        regAWrite <= 1'b0;
        regBWrite <= 1'b0;
        aluOutWrite <= 1'b0;
        resetOut <= 1'b0;
        aluOp <= 3'b000;
        pcSource <= 2'b00;
        iorD <= 3'b000;
        regDst <= 2'b00;
        dataSrc <= 3'b000;
        aluSrcA <= 2'b00;
        aluSrcB <= 2'b00;
        storeSize <= 2'b00;
        loadSize <= 2'b00;
        if (reset || phase == phReset) begin
            // Register file cleared through the reset data source
            resetOut <= 1'b1;
            regWrite <= 1'b1;
            dataSrc <= 3'b100;
        end else begin
            case (phase)
                phFetch: begin
                    pcSource <= 2'b01;
                    if (step != fetchLast) begin
                        // PC+4 on the ALU while memory is read
                        aluOp <= 3'b001;
                        dataSrc <= 3'b100;
                        aluSrcA <= 2'b01;
                        aluSrcB <= (step == decodeStep) ? 2'b11 : 2'b01;
                    end
                    if (step == irStep) begin
                        irWrite <= 1'b1;
                        pcWrite <= 1'b1;
                    end
                    if (step == decodeStep) begin
                        regAWrite <= 1'b1;
                        regBWrite <= 1'b1;
                        aluOutWrite <= 1'b1;
                    end
                end
                phLoad, phStore: begin
                    aluOp <= 3'b001;
                    aluSrcA <= 2'b10;
                    if (step == '0) begin
                        aluOutWrite <= 1'b1;
                    end else begin
                        iorD <= 3'b110;
                    end
                    if (phase == phLoad) begin
                        pcSource <= 2'b01;
                        aluSrcB <= 2'b11;
                        dataSrc <= (step == memLast) ? 3'b111 : 3'b100;
                        if (step == memLast) begin
                            regWrite <= 1'b1;
                            regDst <= 2'b11;
                            loadSize <= size;
                        end
                    end else begin
                        aluSrcB <= 2'b01;
                        if (step == memLast) begin
                            memWrite <= 1'b1;
                            storeSize <= size;
                        end
                    end
                end
                phLui: begin
                    regWrite <= 1'b1;
                    regDst <= 2'b01;
                    dataSrc <= 3'b101;
                    pcSource <= 2'b01;
                end
                phBreak: begin
                    aluOp <= 3'b010;
                    pcSource <= 2'b01;
                    aluSrcA <= 2'b01;
                    aluSrcB <= 2'b01;
                    pcWrite <= (step == '0);
                end
                phRte: begin
                    pcSource <= 2'b11;
                    pcWrite <= (step == '0);
                end
                phSoftReset: begin
                    resetOut <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    noWriteClash: assert property (@(posedge clk) disable iff (reset)
        !(memWrite && regWrite));

    irAfterFetch3: assert property (@(posedge clk) disable iff (reset)
        irWrite |-> $past(phase == phFetch && step == irStep));

endmodule

`default_nettype wire

//--- design/stepSequencer.sv
`default_nettype none
`timescale 1ns/10ps

`include "ctrl_cfg.svh"

module stepSequencer import ctrlPkg::*; (
    input wire clk,
    input wire reset,
    input wire opClass_t opClass,
    input wire memSize_t memSize,
    output phase_t phase,
    output logic [`CTRL_STEP_W-1:0] step,
    output memSize_t size
);

    localparam logic [`CTRL_STEP_W-1:0] fetchLast = `CTRL_STEP_W'(`CTRL_FETCH_STEPS - 1);

    // Address step, memory waits, then the final step
    localparam logic [`CTRL_STEP_W-1:0] memLast = `CTRL_STEP_W'(`CTRL_MEM_WAIT + 1);

    logic dispatchNow;

    function automatic logic [`CTRL_STEP_W-1:0] lastStep(phase_t ph);
        case (ph)
            phFetch: return fetchLast;
            phLoad, phStore: return memLast;
            phBreak, phRte: return `CTRL_STEP_W'(1);
            default: return '0;
        endcase
    endfunction

    function automatic phase_t dispatch(opClass_t cls);
        case (cls)
            clsLoad: return phLoad;
            clsStore: return phStore;
            clsLui: return phLui;
            clsBreak: return phBreak;
            clsRte: return phRte;
            clsSoftReset: return phSoftReset;
            // Unsupported codes skip execute entirely
            default: return phFetch;
        endcase
    endfunction

    assign dispatchNow = (phase == phFetch) && (step == fetchLast);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= phReset;
            step <= '0;
        end else if (dispatchNow) begin
            phase <= dispatch(opClass);
            step <= '0;
        end else if (step == lastStep(phase)) begin
            // Also covers the single cycle in phReset after release
            phase <= phFetch;
            step <= '0;
        end else begin
            step <= step + `CTRL_STEP_W'(1);
        end
    end

    // Size held for the whole execute phase
    always_ff @(posedge clk) begin
        if (dispatchNow) begin
            size <= memSize;
        end
    end

    stepInRange: assert property (@(posedge clk) disable iff (reset)
        step <= lastStep(phase));

    classKnown: assert property (@(posedge clk) disable iff (reset)
        dispatchNow |-> !$isunknown(opClass));

endmodule

`default_nettype wire

//--- design/instrDecoder.sv
`default_nettype none
`timescale 1ns/10ps

`include "ctrl_cfg.svh"

module instrDecoder import ctrlPkg::*; (
    input wire instrWord_t instr,
    output opClass_t opClass,
    output memSize_t memSize
);

    always_comb begin
        opClass = clsNone;
        memSize = sizeWord;
        case (instr.iView.opcode)
            `CTRL_OP_RTYPE: begin
                // Only BREAK and RTE are executed among R-type codes
                case (instr.rView.funct)
                    `CTRL_FUNCT_BREAK: opClass = clsBreak;
                    `CTRL_FUNCT_RTE: opClass = clsRte;
                    default: opClass = clsNone;
                endcase
            end
            `CTRL_OP_LW: begin
                opClass = clsLoad;
            end
            `CTRL_OP_LH: begin
                opClass = clsLoad;
                memSize = sizeHalf;
            end
            `CTRL_OP_LB: begin
                opClass = clsLoad;
                memSize = sizeByte;
            end
            `CTRL_OP_SW: begin
                opClass = clsStore;
            end
            `CTRL_OP_SH: begin
                opClass = clsStore;
                memSize = sizeHalf;
            end
            `CTRL_OP_SB: begin
                opClass = clsStore;
                memSize = sizeByte;
            end
            `CTRL_OP_LUI: begin
                opClass = clsLui;
            end
            `CTRL_OP_RESET: begin
                opClass = clsSoftReset;
            end
            default: begin
                opClass = clsNone;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/ctrlPkg.sv
`default_nettype none

`include "ctrl_cfg.svh"

package ctrlPkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields_t;

    // Immediate fills what opcode, rs and rt leave over
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [`CTRL_INSTR_W-17:0] imm;
    } iFields_t;

    typedef union packed {
        rFields_t rView;
        iFields_t iView;
    } instrWord_t;

    typedef enum logic [2:0] {
        clsNone,
        clsLoad,
        clsStore,
        clsLui,
        clsBreak,
        clsRte,
        clsSoftReset
    } opClass_t;

    // Encoded as the datapath expects on loadSize and storeSize
    typedef enum logic [1:0] {
        sizeWord = 2'b01,
        sizeHalf = 2'b11,
        sizeByte = 2'b10
    } memSize_t;

    typedef enum logic [2:0] {
        phReset,
        phFetch,
        phLoad,
        phStore,
        phLui,
        phBreak,
        phRte,
        phSoftReset
    } phase_t;

endpackage

`default_nettype wire

//--- design/ctrl_cfg.svh
`ifndef CTRL_CFG_SVH
`define CTRL_CFG_SVH

// Word and counter widths
`define CTRL_INSTR_W 32
`define CTRL_STEP_W 3

// Sequence lengths in clock cycles
`define CTRL_FETCH_STEPS 6
`define CTRL_MEM_WAIT 3

// Opcodes in instr[31:26]
`define CTRL_OP_RTYPE 6'b000000
`define CTRL_OP_LW 6'b100011
`define CTRL_OP_LH 6'b100001
`define CTRL_OP_LB 6'b100000
`define CTRL_OP_SW 6'b101011
`define CTRL_OP_SH 6'b101001
`define CTRL_OP_SB 6'b101000
`define CTRL_OP_LUI 6'b001111
`define CTRL_OP_RESET 6'b111111

// Funct codes under the R-type opcode
`define CTRL_FUNCT_BREAK 6'b001101
`define CTRL_FUNCT_RTE 6'b010011

`endif
